//--- rtl/tdc_pkg.sv
package tdc_pkg;

  localparam int NUM_CH       = 4;
  localparam int CLKS_PER_BIT = 16;    // host uart oversampling
  localparam int SPI_HALF     = 3;     // clocks per sck phase
  localparam int START_PULSE  = 4;
  localparam int INTB_TIMEOUT = 2000;
  localparam int REC_BYTES    = 7;

  localparam logic [7:0]  CMD_MEASURE  = 8'h4D;  // ascii M
  // auto-increment read starting at TIME1
  localparam logic [7:0]  RD_CMD       = 8'h90;
  localparam logic [23:0] TIMEOUT_TIME = 24'hFF_FFFF;

  typedef struct packed {
    logic [7:0]  ch;
    logic [23:0] time1;
    logic [23:0] calib1;
  } tdc_fields_t;

  // same 56 bits, either as fields or as bytes in uart order
  typedef union packed {
    tdc_fields_t                     f;
    logic [0:REC_BYTES-1][7:0]       b;  // b[0] is the channel id
  } tdc_record_u;

endpackage

//--- rtl/host_command.sv
module host_command (
  input  logic clk,
  input  logic rst,
  input  logic uart_rx,
  input  logic round_busy,
  output logic measure
);
  import tdc_pkg::*;

  logic                            rx_meta;
  logic                            rx_s;     // synchronized serial line
  logic                            rx_act;   // frame in progress
  logic [3:0]                      bit_idx;  // 0 start, 1..8 data, 9 stop
  logic [$clog2(CLKS_PER_BIT)-1:0] cnt;
  logic [7:0]                      shreg;
  logic                            bit_end;

  // start bit is checked at half a bit, the rest one bit apart
  assign bit_end = rx_act && ((bit_idx == 4'd0) ? (int'(cnt) == CLKS_PER_BIT / 2 - 1)
                                                : (int'(cnt) == CLKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    rx_meta <= uart_rx;
    rx_s    <= rx_meta;
    measure <= 1'b0;
    if (rst) begin
      rx_meta <= 1'b1;
      rx_s    <= 1'b1;
      rx_act  <= 1'b0;
      bit_idx <= '0;
      cnt     <= '0;
      measure <= 1'b0;
    end else if (!rx_act) begin
      cnt     <= '0;
      bit_idx <= '0;
      rx_act  <= !rx_s;  // falling edge opens a frame
    end else if (bit_end) begin
      cnt     <= '0;
      bit_idx <= bit_idx + 1'b1;
      if (bit_idx == 4'd0) begin
        rx_act <= !rx_s;  // glitch, not a start bit
      end else if (bit_idx == 4'd9) begin
        rx_act <= 1'b0;
        // valid stop bit, right byte, nothing running
        measure <= rx_s && (shreg == CMD_MEASURE) && !round_busy;
      end else begin
        shreg <= {rx_s, shreg[7:1]};  // lsb first
      end
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- rtl/tdc_spi_master.sv
module tdc_spi_master (
  input  logic       clk,
  input  logic       rst,
  input  logic       spi_start,
  input  logic [7:0] tx_byte,
  input  logic       cs_hold,
  output logic       busy,
  output logic       done,
  output logic [7:0] rx_byte,
  output logic       cs,
  output logic       sck,
  output logic       mosi,
  input  logic       miso
);
  import tdc_pkg::*;

  logic [$clog2(SPI_HALF+1)-1:0] cnt;
  logic [2:0]                    bit_cnt;
  logic [7:0]                    tx_sh;
  logic [7:0]                    rx_sh;

  assign mosi    = tx_sh[7];  // msb first
  assign rx_byte = rx_sh;     // complete when done pulses

  always_ff @(posedge clk) begin
    done <= 1'b0;
    if (rst) begin
      busy    <= 1'b0;
      done    <= 1'b0;
      cs      <= 1'b1;
      sck     <= 1'b0;
      cnt     <= '0;
      bit_cnt <= '0;
      tx_sh   <= '0;
    end else if (!busy) begin
      cnt     <= '0;
      bit_cnt <= '0;
      if (spi_start) begin
        busy  <= 1'b1;
        cs    <= 1'b0;
        tx_sh <= tx_byte;
      end else if (!cs_hold) begin
        cs <= 1'b1;  // frame over
      end
    end else if (int'(cnt) == SPI_HALF - 1) begin
      cnt <= '0;
      sck <= !sck;
      if (!sck) begin
        rx_sh <= {rx_sh[6:0], miso};  // rising edge samples
      end else begin
        tx_sh   <= {tx_sh[6:0], 1'b0};  // falling edge shifts
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == 3'd7) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- rtl/tdc_channel.sv
module tdc_channel (
  input  logic                clk,
  input  logic                rst,
  input  logic [7:0]          ch_id,
  input  logic                measure,
  input  logic                rec_take,
  output logic                rec_valid,
  output tdc_pkg::tdc_record_u rec_data,
  output logic                tdc_start,
  input  logic                tdc_intb,
  output logic                tdc_cs,
  output logic                tdc_sck,
  output logic                tdc_mosi,
  input  logic                tdc_miso
);
  import tdc_pkg::*;

  logic                            intb_meta;
  logic                            intb_s;
  logic                            waiting;   // start sent, interrupt pending
  logic                            reading;   // spi frame running
  logic [$clog2(INTB_TIMEOUT)-1:0] cnt;
  logic [2:0]                      byte_idx;
  logic                            spi_start;
  logic [7:0]                      spi_byte;
  logic                            spi_done;
  logic [7:0]                      spi_rx;
  logic [47:0]                     result;
  logic [47:0]                     result_next;

  // command reply falls out the top after six more bytes
  assign result_next = {result[39:0], spi_rx};

  tdc_spi_master spi (
    .clk(clk),
    .rst(rst),
    .spi_start(spi_start),
    .tx_byte(spi_byte),
    .cs_hold(reading),
    .busy(),
    .done(spi_done),
    .rx_byte(spi_rx),
    .cs(tdc_cs),
    .sck(tdc_sck),
    .mosi(tdc_mosi),
    .miso(tdc_miso)
  );

  always_ff @(posedge clk) begin
    intb_meta <= tdc_intb;
    intb_s    <= intb_meta;
    spi_start <= 1'b0;
    if (rst) begin
      intb_meta <= 1'b1;
      intb_s    <= 1'b1;
      tdc_start <= 1'b0;
      waiting   <= 1'b0;
      reading   <= 1'b0;
      rec_valid <= 1'b0;
      spi_start <= 1'b0;
      cnt       <= '0;
      byte_idx  <= '0;
    end else begin
      if (measure && !tdc_start && !waiting && !reading && !rec_valid) begin
        tdc_start <= 1'b1;
        cnt       <= '0;
      end
      if (tdc_start) begin
        if (int'(cnt) == START_PULSE - 1) begin
          tdc_start <= 1'b0;
          waiting   <= 1'b1;
          cnt       <= '0;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
      if (waiting) begin
        if (!intb_s) begin
          waiting   <= 1'b0;
          reading   <= 1'b1;
          spi_start <= 1'b1;
          spi_byte  <= RD_CMD;
          byte_idx  <= '0;
        end else if (int'(cnt) == INTB_TIMEOUT - 1) begin
          waiting              <= 1'b0;  // no spi traffic at all
          rec_valid            <= 1'b1;
          rec_data.f.ch        <= ch_id;
          rec_data.f.time1     <= TIMEOUT_TIME;
          rec_data.f.calib1    <= '0;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
      if (reading && spi_done) begin
        result   <= result_next;
        byte_idx <= byte_idx + 1'b1;
        if (byte_idx == 3'd6) begin
          reading           <= 1'b0;  // lets cs rise
          rec_valid         <= 1'b1;
          rec_data.f.ch     <= ch_id;
          rec_data.f.time1  <= result_next[47:24];
          rec_data.f.calib1 <= result_next[23:0];
        end else begin
          spi_start <= 1'b1;
          spi_byte  <= 8'h00;  // dummy, clocks out the next reply
        end
      end
      if (rec_take) rec_valid <= 1'b0;
    end
  end

endmodule

//--- rtl/uart_tx.sv
module uart_tx (
  input  logic       clk,
  input  logic       rst,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx_busy,
  output logic       tx
);
  import tdc_pkg::*;

  logic [9:0]                      shreg;  // stop, data, start
  logic [3:0]                      bit_idx;
  logic [$clog2(CLKS_PER_BIT)-1:0] cnt;

  assign tx = shreg[0];

  always_ff @(posedge clk) begin
    if (rst) begin
      shreg   <= '1;  // line idles high
      tx_busy <= 1'b0;
      bit_idx <= '0;
      cnt     <= '0;
    end else if (!tx_busy) begin
      cnt     <= '0;
      bit_idx <= '0;
      if (tx_start) begin
        shreg   <= {1'b1, tx_byte, 1'b0};
        tx_busy <= 1'b1;
      end
    end else if (int'(cnt) == CLKS_PER_BIT - 1) begin
      cnt   <= '0;
      shreg <= {1'b1, shreg[9:1]};
      if (bit_idx == 4'd9) tx_busy <= 1'b0;  // stop bit done
      else bit_idx <= bit_idx + 1'b1;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- rtl/result_collector.sv
module result_collector (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic                                          measure,
  input  logic                 [tdc_pkg::NUM_CH-1:0]    rec_valid,
  input  tdc_pkg::tdc_record_u [tdc_pkg::NUM_CH-1:0]    rec_data,
  output logic                 [tdc_pkg::NUM_CH-1:0]    rec_take,
  output logic                                          round_busy,
  output logic                                          tx_start,
  output logic                 [7:0]                    tx_byte,
  output logic                                          tx
);
  import tdc_pkg::*;

  logic [$clog2(NUM_CH)-1:0] idx;        // channel being drained
  logic                      have_rec;   // rec_buf holds unsent bytes
  logic                      last_sent;  // final byte handed to uart
  logic [2:0]                byte_idx;
  tdc_record_u               rec_buf;
  logic                      tx_busy;
  logic                      tx_free;

  // busy only rises the cycle after a start
  assign tx_free = !tx_busy && !tx_start;

  uart_tx uart_tx (
    .clk(clk),
    .rst(rst),
    .tx_start(tx_start),
    .tx_byte(tx_byte),
    .tx_busy(tx_busy),
    .tx(tx)
  );

  always_ff @(posedge clk) begin
    rec_take <= '0;
    tx_start <= 1'b0;
    if (rst) begin
      rec_take   <= '0;
      tx_start   <= 1'b0;
      round_busy <= 1'b0;
      idx        <= '0;
      have_rec   <= 1'b0;
      last_sent  <= 1'b0;
    end else if (measure) begin
      round_busy <= 1'b1;
      idx        <= '0;
      have_rec   <= 1'b0;
      last_sent  <= 1'b0;
    end else if (round_busy) begin
      if (last_sent) begin
        if (tx_free) begin  // wait out the stop bit
          round_busy <= 1'b0;
          last_sent  <= 1'b0;
        end
      end else if (!have_rec) begin
        // strict channel order, no skipping
        if (rec_valid[idx]) begin
          rec_take[idx] <= 1'b1;
          rec_buf       <= rec_data[idx];
          have_rec      <= 1'b1;
          byte_idx      <= '0;
        end
      end else if (tx_free) begin
        tx_start <= 1'b1;
        tx_byte  <= rec_buf.b[byte_idx];
        byte_idx <= byte_idx + 1'b1;
        if (byte_idx == 3'(REC_BYTES - 1)) begin
          have_rec <= 1'b0;
          if (int'(idx) == NUM_CH - 1) last_sent <= 1'b1;
          else idx <= idx + 1'b1;
        end
      end
    end
  end

endmodule

//--- rtl/tdc_readout_top.sv
module tdc_readout_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       uart_rx,
  output logic                       uart_tx,
  output logic [tdc_pkg::NUM_CH-1:0] tdc_start,
  input  logic [tdc_pkg::NUM_CH-1:0] tdc_intb,
  output logic [tdc_pkg::NUM_CH-1:0] tdc_cs,
  output logic [tdc_pkg::NUM_CH-1:0] tdc_sck,
  output logic [tdc_pkg::NUM_CH-1:0] tdc_mosi,
  input  logic [tdc_pkg::NUM_CH-1:0] tdc_miso
);
  import tdc_pkg::*;

  logic                     measure;     // round start strobe
  logic                     round_busy;
  logic [NUM_CH-1:0]        rec_valid;
  logic [NUM_CH-1:0]        rec_take;
  tdc_record_u [NUM_CH-1:0] rec_data;

  host_command host_command (
    .clk(clk),
    .rst(rst),
    .uart_rx(uart_rx),
    .round_busy(round_busy),
    .measure(measure)
  );

  for (genvar i = 0; i < NUM_CH; i++) begin : ch
    tdc_channel channel (
      .clk(clk),
      .rst(rst),
      .ch_id(8'(i)),  // record identity
      .measure(measure),
      .rec_take(rec_take[i]),
      .rec_valid(rec_valid[i]),
      .rec_data(rec_data[i]),
      .tdc_start(tdc_start[i]),
      .tdc_intb(tdc_intb[i]),
      .tdc_cs(tdc_cs[i]),
      .tdc_sck(tdc_sck[i]),
      .tdc_mosi(tdc_mosi[i]),
      .tdc_miso(tdc_miso[i])
    );
  end

  result_collector result_collector (
    .clk(clk),
    .rst(rst),
    .measure(measure),
    .rec_valid(rec_valid),
    .rec_data(rec_data),
    .rec_take(rec_take),
    .round_busy(round_busy),
    .tx_start(),
    .tx_byte(),
    .tx(uart_tx)
  );

endmodule

//--- tests/tdc_readout_checker.sv
module tdc_readout_checker (
  input logic                       clk,
  input logic                       rst,
  input logic                       measure,
  input logic                       uart_tx,
  input logic [tdc_pkg::NUM_CH-1:0] tdc_start,
  input logic [tdc_pkg::NUM_CH-1:0] tdc_intb,
  input logic [tdc_pkg::NUM_CH-1:0] tdc_cs,
  input logic [tdc_pkg::NUM_CH-1:0] tdc_sck
);
  import tdc_pkg::*;

  int errors = 0;

  // idle levels through reset and on the first cycle after it
  assert property (@(posedge clk) rst |=> uart_tx && (&tdc_cs) && !(|tdc_sck) && !(|tdc_start))
    else begin
      $error("outputs not at their idle levels around reset");
      errors++;
    end

  for (genvar i = 0; i < NUM_CH; i++) begin : lane
    logic       sck_q;
    logic [6:0] sck_rises;  // rising sck edges seen in the current frame

    always_ff @(posedge clk) begin
      sck_q <= tdc_sck[i];
      if (rst || tdc_cs[i]) sck_rises <= '0;
      else if (tdc_sck[i] && !sck_q) sck_rises <= sck_rises + 1'b1;
    end

    assert property (@(posedge clk) disable iff (rst) !$stable(tdc_sck[i]) |-> !tdc_cs[i])
      else begin
        $error("sck moved while chip select was high on channel %0d", i);
        errors++;
      end

    // command plus six reply bytes under one chip select
    assert property (@(posedge clk) disable iff (rst) $rose(tdc_cs[i]) |-> sck_rises == 7'd56)
      else begin
        $error("chip select frame did not carry seven bytes on channel %0d", i);
        errors++;
      end

    // a silent converter never gets selected
    assert property (@(posedge clk) disable iff (rst) $fell(tdc_cs[i]) |-> !tdc_intb[i])
      else begin
        $error("chip select fell without an interrupt on channel %0d", i);
        errors++;
      end

    assert property (@(posedge clk) disable iff (rst)
        $fell(tdc_start[i]) |-> $past(tdc_start[i], START_PULSE)
                                && !$past(tdc_start[i], START_PULSE + 1)
                                && $past(measure, START_PULSE + 1))
      else begin
        $error("start pulse on channel %0d has wrong width or no measure before it", i);
        errors++;
      end
  end

endmodule

bind tdc_readout_top tdc_readout_checker checks (
  .clk(clk),
  .rst(rst),
  .measure(measure),
  .uart_tx(uart_tx),
  .tdc_start(tdc_start),
  .tdc_intb(tdc_intb),
  .tdc_cs(tdc_cs),
  .tdc_sck(tdc_sck)
);

//--- tests/tdc_readout_tb.sv
module tdc_readout_tb;
  import tdc_pkg::*;

  localparam int ROUNDS = 4;
  // each round may sit out the full timeout and then send every record
  localparam int WATCH_CYCLES = 2 * ROUNDS * NUM_CH * (INTB_TIMEOUT + 7 * 10 * CLKS_PER_BIT);

  logic              clk = 1'b0;
  logic              rst = 1'b1;
  logic              uart_rx = 1'b1;
  logic              uart_tx;
  logic [NUM_CH-1:0] tdc_start;
  wire  [NUM_CH-1:0] tdc_intb;
  logic [NUM_CH-1:0] tdc_cs;
  logic [NUM_CH-1:0] tdc_sck;
  logic [NUM_CH-1:0] tdc_mosi;
  wire  [NUM_CH-1:0] tdc_miso;

  logic [47:0]       result [NUM_CH];  // TIME1 then CALIB1
  int                delay [NUM_CH];
  logic [NUM_CH-1:0] silent = '0;
  logic [7:0]        cmd_rx [NUM_CH];  // first byte each converter saw
  logic [7:0]        rx_q [$];         // bytes decoded from the tx line
  int                fails = 0;
  int                fails_before = 0;
  int                n_pass = 0;
  int                n_fail = 0;

  tdc_readout_top UUT (
    .clk(clk),
    .rst(rst),
    .uart_rx(uart_rx),
    .uart_tx(uart_tx),
    .tdc_start(tdc_start),
    .tdc_intb(tdc_intb),
    .tdc_cs(tdc_cs),
    .tdc_sck(tdc_sck),
    .tdc_mosi(tdc_mosi),
    .tdc_miso(tdc_miso)
  );

  always #10 clk = ~clk;

  for (genvar g = 0; g < NUM_CH; g++) begin : conv
    logic        intb = 1'b1;
    logic        miso = 1'b0;
    logic        sck_q = 1'b0;
    logic [55:0] sh = '0;  // command slot, TIME1, CALIB1
    int          nbits = 0;

    assign tdc_intb[g] = intb;
    assign tdc_miso[g] = miso;

    initial begin
      forever begin
        @(posedge tdc_start[g]);
        if (!silent[g]) begin
          repeat (delay[g]) @(negedge clk);
          intb = 1'b0;
          @(posedge tdc_cs[g]);  // released once the frame closes
          @(negedge clk);
          intb = 1'b1;
        end
      end
    end

    // mode 0 slave shifts on falling sck and reads mosi while sck is high
    always @(negedge clk) begin
      sck_q <= tdc_sck[g];
      if (tdc_cs[g]) begin
        sh    <= {8'h00, result[g]};
        miso  <= 1'b0;
        nbits <= 0;
      end else if (tdc_sck[g] && !sck_q) begin
        if (nbits < 8) cmd_rx[g] <= {cmd_rx[g][6:0], tdc_mosi[g]};
        nbits <= nbits + 1;
      end else if (!tdc_sck[g] && sck_q) begin
        sh   <= {sh[54:0], 1'b0};
        miso <= sh[54];
      end
    end
  end

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int k = 0; k < 10; k++) begin
      uart_rx = frame[k];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
  endtask

  task automatic check_round();
    logic [55:0] rec;
    logic [7:0]  got;
    assert (rx_q.size() == NUM_CH * REC_BYTES) else begin
      $display("mismatch at %0t: expected %0d bytes, received %0d",
               $time, NUM_CH * REC_BYTES, rx_q.size());
      fails++;
    end
    for (int c = 0; c < NUM_CH; c++) begin
      rec = silent[c] ? {8'(c), TIMEOUT_TIME, 24'h00_0000} : {8'(c), result[c]};
      assert (silent[c] || cmd_rx[c] == RD_CMD) else begin
        $display("mismatch at %0t: channel %0d read command %02h", $time, c, cmd_rx[c]);
        fails++;
      end
      for (int k = 0; k < REC_BYTES; k++) begin
        if (rx_q.size() > 0) got = rx_q.pop_front();
        else got = ~rec[55 - 8 * k -: 8];  // missing byte counts as wrong
        assert (got == rec[55 - 8 * k -: 8]) else begin
          $display("mismatch at %0t: channel %0d byte %0d expected %02h received %02h",
                   $time, c, k, rec[55 - 8 * k -: 8], got);
          fails++;
        end
      end
    end
    rx_q.delete();
  endtask

  task automatic run_round(input logic [NUM_CH-1:0] mask, input logic repeat_cmd);
    for (int c = 0; c < NUM_CH; c++) begin
      result[c] = {16'($urandom), $urandom};
      delay[c]  = 5 + int'($urandom % 296);
    end
    silent = mask;
    send_byte(CMD_MEASURE);
    assert (UUT.round_busy) else begin
      $display("round did not start after the measure command at %0t", $time);
      fails++;
    end
    if (repeat_cmd) send_byte(CMD_MEASURE);  // lands mid round
    wait (!UUT.round_busy);
    @(negedge clk);
    check_round();
  endtask

  task automatic finish_test(input string name);
    int total;
    total = fails + UUT.checks.errors;
    if (total == fails_before) begin
      n_pass++;
      $display("%s: pass", name);
    end else begin
      n_fail++;
      $display("%s: fail with %0d errors", name, total - fails_before);
    end
    fails_before = total;
  endtask

  // host side of the tx line
  initial begin : host_rx
    logic [7:0] b;
    forever begin
      @(negedge clk);
      if (!rst && !uart_tx) begin
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        for (int k = 0; k < 8; k++) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          b[k] = uart_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        assert (uart_tx) else begin
          $display("stop bit missing on the tx line at %0t", $time);
          fails++;
        end
        rx_q.push_back(b);
      end
    end
  end

  initial begin : watchdog
    repeat (WATCH_CYCLES) @(negedge clk);
    $display("watchdog expired after %0d cycles, run did not complete", WATCH_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin : main
    void'($urandom(32'h6f6e_7c99));
    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    assert (uart_tx && (&tdc_cs) && tdc_start == '0 && tdc_sck == '0) else begin
      $display("outputs not idle after reset at %0t", $time);
      fails++;
    end
    finish_test("reset state");

    run_round('0, 1'b0);
    finish_test("all channels answer");

    run_round(NUM_CH'(5), 1'b0);  // channels 0 and 2 stay silent
    finish_test("interrupt timeout");

    send_byte(8'h41);
    repeat (20 * CLKS_PER_BIT) @(negedge clk);
    assert (rx_q.size() == 0 && !UUT.round_busy && tdc_start == '0) else begin
      $display("a byte other than the measure command started activity at %0t", $time);
      fails++;
    end
    run_round('0, 1'b1);
    run_round('0, 1'b0);
    finish_test("command filtering");

    $display("tests passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
rtl/tdc_pkg.sv
rtl/host_command.sv
rtl/tdc_spi_master.sv
rtl/tdc_channel.sv
rtl/uart_tx.sv
rtl/result_collector.sv
rtl/tdc_readout_top.sv
tests/tdc_readout_checker.sv
tests/tdc_readout_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the tdc readout testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f \
    --top-module tdc_readout_tb --Mdir obj_dir -o tdc_readout_sim; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tdc_readout_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TESTBENCH PASSED" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
